// File: bench/raster_patterns.txt
# columns: chip code, frames to run, raster_x_max, raster_y_max
# chip codes: 0 6567R8, 1 6569R3, 2 6567R56A, 3 6569R1
0 2 519 262
1 1 503 311
2 1 511 261
3 1 503 311
0 1 519 262

// File: compile.f
+incdir+design
design/vic_chip_pkg.sv
design/vic_raster_pkg.sv
design/dot_phase_gen.sv
design/chip_geometry_decode.sv
design/raster_counter.sv
design/sync_blank_gen.sv
design/vic_raster_top.sv
bench/tb_vic_raster.sv

// File: Makefile
TOP := tb_vic_raster

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/tb_vic_raster.sv
`timescale 1ns/1ns
`include "vic_settings.svh"

module tb_vic_raster;

    // one test holds a chip code, the frames to run, the last pixel and the last line
    typedef struct packed {
        longint chip;
        longint frames;
        longint x_max;
        longint y_max;
    } pattern_t;

    logic                         clk_dot4x;
    logic                         rst;
    vic_chip_pkg::chip_model_t    chip;
    vic_raster_pkg::raster_pos_t  pos;
    logic [6:0]                   cycle_num;
    vic_raster_pkg::sync_out_t    sync;

    pattern_t                     patterns[$];
    longint                       watchdog_ns;
    bit                           limit_ready;

    // reference model state
    vic_chip_pkg::chip_geometry_t ref_geom;
    vic_raster_pkg::raster_pos_t  ref_pos;
    vic_raster_pkg::sync_out_t    ref_sync;
    int                           edges;
    longint                       pixels;

    vic_raster_top u_vic_raster_top (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .pos       (pos),
        .cycle_num (cycle_num),
        .sync      (sync)
    );

    always #10 clk_dot4x = ~clk_dot4x;

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string field, input int got, input int want);
        $display("ERR %0t ns: %s is 0x%0h, expected 0x%0h", $time, field, got, want);
        fail_run();
    endtask

    task automatic check_pos(input vic_raster_pkg::raster_pos_t want);
        if (pos.xpos !== want.xpos)
            report_mismatch("xpos", int'(pos.xpos), int'(want.xpos));
        if (pos.raster_x !== want.raster_x)
            report_mismatch("raster_x", int'(pos.raster_x), int'(want.raster_x));
        if (pos.sprite_raster_x !== want.sprite_raster_x)
            report_mismatch("sprite_raster_x", int'(pos.sprite_raster_x),
                            int'(want.sprite_raster_x));
        if (pos.raster_line !== want.raster_line)
            report_mismatch("raster_line", int'(pos.raster_line), int'(want.raster_line));
        if (pos.raster_line_d !== want.raster_line_d)
            report_mismatch("raster_line_d", int'(pos.raster_line_d), int'(want.raster_line_d));
    endtask

    task automatic check_sync(input vic_raster_pkg::sync_out_t want);
        if (sync.hsync !== want.hsync)
            report_mismatch("hsync", int'(sync.hsync), int'(want.hsync));
        if (sync.vsync !== want.vsync)
            report_mismatch("vsync", int'(sync.vsync), int'(want.vsync));
        if (sync.blank !== want.blank)
            report_mismatch("blank", int'(sync.blank), int'(want.blank));
    endtask

    task automatic check_cycle(input logic [6:0] want);
        if (cycle_num !== want)
            report_mismatch("cycle_num", int'(cycle_num), int'(want));
    endtask

    // geometry the DUT should use for a pattern line
    function automatic vic_chip_pkg::chip_geometry_t expected_geometry(input pattern_t p);
        vic_chip_pkg::chip_geometry_t g;
        vic_chip_pkg::chip_model_t    model;
        model = vic_chip_pkg::chip_model_t'(p.chip[1:0]);
        g = '0;
        g.raster_x_max = p.x_max[`VIC_X_BITS-1:0];
        g.raster_y_max = p.y_max[`VIC_Y_BITS-1:0];
        g.is_r8 = model == vic_chip_pkg::CHIP6567R8;
        if (model == vic_chip_pkg::CHIP6569R1 || model == vic_chip_pkg::CHIP6569R3) begin
            g.xpos_start  = 10'h194;
            g.hsync_start = 10'h17c;
            g.hsync_end   = 10'h1ac;
            g.vblank_end  = 9'd16;
        end else begin
            g.xpos_start  = 10'h19c;
            g.hsync_start = 10'h18c;
            g.hsync_end   = 10'h1bc;
            g.vblank_end  = 9'd28;
        end
        g.xpos_cycle0 = g.xpos_start + 10'd1;
        // R8 lines are one cycle longer
        g.sprite_start = g.is_r8 ? 10'd80 : 10'd72;
        return g;
    endfunction

    // one rising edge of the reference model
    task automatic advance_model();
        vic_raster_pkg::raster_pos_t nxt;
        logic [6:0] cyc;
        logic [2:0] pix;
        int ph;
        nxt = ref_pos;
        cyc = ref_pos.raster_x[`VIC_X_BITS-1:3];
        pix = ref_pos.raster_x[2:0];
        // sync is registered from the position held before the edge
        ref_sync.hsync = (ref_pos.xpos >= ref_geom.hsync_start) &&
                         (ref_pos.xpos < ref_geom.hsync_end);
        ref_sync.vsync = ref_pos.raster_line < 9'd3;
        ref_sync.blank = ref_sync.hsync || (ref_pos.raster_line < ref_geom.vblank_end);
        edges = edges + 1;
        // the counter sees tick 0 of the phase on the second edge after reset
        ph = (edges - 2) % `VIC_TICKS_PER_PHI;
        if (edges >= 2 && ph >= `VIC_TICKS_PER_PHI / 2)
            nxt.raster_line_d = ref_pos.raster_line;
        if (edges >= 2 && ph % `VIC_TICKS_PER_DOT == 0) begin
            pixels = pixels + 1;
            nxt.sprite_raster_x = 10'((longint'(ref_geom.sprite_start) + pixels) %
                                      (longint'(ref_geom.raster_x_max) + 1));
            if (ref_pos.raster_x == ref_geom.raster_x_max) begin
                nxt.raster_x = '0;
                nxt.xpos = ref_geom.xpos_start;
                if (ref_pos.raster_line == ref_geom.raster_y_max)
                    nxt.raster_line = '0;
                else
                    nxt.raster_line = ref_pos.raster_line + 9'd1;
            end else begin
                nxt.raster_x = ref_pos.raster_x + 10'd1;
                if (cyc == 7'd0 && pix == 3'd0)
                    nxt.xpos = ref_geom.xpos_cycle0;
                else if (cyc == 7'd12 && pix == 3'd3)
                    nxt.xpos = '0;
                else if (ref_geom.is_r8 && ((cyc == 7'd60 && pix == 3'd7) ||
                         (cyc == 7'd61 && (pix == 3'd3 || pix == 3'd7))))
                    nxt.xpos = 10'h184;
                else
                    nxt.xpos = ref_pos.xpos + 10'd1;
            end
        end
        ref_pos = nxt;
    endtask

    task automatic run_pattern(input pattern_t p);
        longint total;
        total = p.frames * (p.x_max + 1) * (p.y_max + 1) * `VIC_TICKS_PER_DOT;
        ref_geom = expected_geometry(p);
        @(negedge clk_dot4x);
        rst  = 1'b1;
        chip = vic_chip_pkg::chip_model_t'(p.chip[1:0]);
        repeat (16) @(negedge clk_dot4x);
        // start values held while rst is high
        ref_pos = '0;
        ref_pos.xpos = ref_geom.xpos_start;
        ref_pos.sprite_raster_x = ref_geom.sprite_start;
        ref_sync = '0;
        check_pos(ref_pos);
        check_cycle(7'd0);
        check_sync(ref_sync);
        rst = 1'b0;
        // a model change outside reset must leave the geometry alone
        chip = vic_chip_pkg::chip_model_t'(p.chip[1:0] ^ 2'b01);
        edges = 0;
        pixels = 0;
        repeat (total) begin
            @(posedge clk_dot4x);
            advance_model();
            @(negedge clk_dot4x);
            check_pos(ref_pos);
            check_cycle(7'(ref_pos.raster_x / 10'd8));
            check_sync(ref_sync);
        end
    endtask

    initial begin
        int       fd;
        int       got;
        string    line;
        pattern_t p;
        longint   c;
        longint   f;
        longint   xm;
        longint   ym;
        clk_dot4x = 1'b0;
        rst = 1'b1;
        chip = vic_chip_pkg::CHIP6567R8;
        limit_ready = 1'b0;
        watchdog_ns = 0;
        fd = $fopen("bench/raster_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file bench/raster_patterns.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                got = $sscanf(line, "%d %d %d %d", c, f, xm, ym);
                if (got != 4 || c < 0 || c > 3 || f < 1) begin
                    $display("malformed line in the pattern file: %s", line);
                    fail_run();
                end
                p = '{c, f, xm, ym};
                patterns.push_back(p);
                watchdog_ns = watchdog_ns + f * (xm + 1) * (ym + 1) * 4 * 20;
            end
        end
        $fclose(fd);
        if (patterns.size() == 0) begin
            $display("the pattern file holds no tests");
            fail_run();
        end
        watchdog_ns = watchdog_ns + watchdog_ns / 10;
        limit_ready = 1'b1;
        foreach (patterns[i])
            run_pattern(patterns[i]);
        $display("Regression passed");
        $finish;
    end

    // ends a run that takes longer than all frames plus a margin
    initial begin
        wait (limit_ready);
        #(watchdog_ns);
        $display("watchdog expired, tests still running after %0d ns", watchdog_ns);
        fail_run();
    end

endmodule

// File: design/vic_raster_top.sv
`timescale 1ns/1ns

module vic_raster_top (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_chip_pkg::chip_model_t   chip,
    output vic_raster_pkg::raster_pos_t pos,
    output logic [6:0]                  cycle_num,
    output vic_raster_pkg::sync_out_t   sync
);

    vic_raster_pkg::dot_strobes_t strobes;
    vic_chip_pkg::chip_geometry_t geom;

    dot_phase_gen u_dot_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .strobes   (strobes)
    );

    chip_geometry_decode u_chip_geometry_decode (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .geom      (geom)
    );

    // pos trails the dot strobe by one cycle
    raster_counter u_raster_counter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .strobes   (strobes),
        .geom      (geom),
        .pos       (pos),
        .cycle_num (cycle_num)
    );

    // sync trails pos by one more cycle
    sync_blank_gen u_sync_blank_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .pos       (pos),
        .geom      (geom),
        .sync      (sync)
    );

endmodule

// File: design/sync_blank_gen.sv
`timescale 1ns/1ns
`include "vic_settings.svh"

module sync_blank_gen (
    input  logic                         clk_dot4x,
    input  logic                         rst,
    input  vic_raster_pkg::raster_pos_t  pos,
    input  vic_chip_pkg::chip_geometry_t geom,
    output vic_raster_pkg::sync_out_t    sync
);

    // vsync covers the first three lines of the frame
    localparam logic [`VIC_Y_BITS-1:0] VSYNC_LINES = 3;

    logic in_hsync;
    logic in_vsync;
    logic in_vblank;

    // window includes hsync_start and ends just before hsync_end
    assign in_hsync  = (pos.xpos >= geom.hsync_start) && (pos.xpos < geom.hsync_end);
    assign in_vsync  = pos.raster_line < VSYNC_LINES;
    assign in_vblank = pos.raster_line < geom.vblank_end;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            sync <= '0;
        end else begin
            sync.hsync <= in_hsync;
            sync.vsync <= in_vsync;
            // blanked during horizontal sync and the top border lines
            sync.blank <= in_hsync || in_vblank;
        end
    end

endmodule

// File: design/raster_counter.sv
`timescale 1ns/1ns
`include "vic_settings.svh"

module raster_counter (
    input  logic                         clk_dot4x,
    input  logic                         rst,
    input  vic_raster_pkg::dot_strobes_t strobes,
    input  vic_chip_pkg::chip_geometry_t geom,
    output vic_raster_pkg::raster_pos_t  pos,
    output logic [6:0]                   cycle_num
);

    localparam logic [`VIC_X_BITS-1:0] X_ONE = 1;
    localparam logic [`VIC_Y_BITS-1:0] Y_ONE = 1;
    // xpos value held twice on the 6567R8
    localparam logic [`VIC_X_BITS-1:0] XPOS_R8_HOLD = 'h184;

    // pixel within the current processor cycle
    logic [2:0] cycle_bit;
    logic       line_end;
    logic       frame_end;

    logic [`VIC_X_BITS-1:0] xpos_next;
    logic [`VIC_X_BITS-1:0] sprite_next;

    assign cycle_num = pos.raster_x[`VIC_X_BITS-1:3];
    assign cycle_bit = pos.raster_x[2:0];

    assign line_end  = pos.raster_x >= geom.raster_x_max;
    assign frame_end = pos.raster_line >= geom.raster_y_max;

    assign sprite_next = (pos.sprite_raster_x >= geom.raster_x_max) ? '0 :
                         pos.sprite_raster_x + X_ONE;

    // xpos normally counts, but jumps at a few fixed points of the line
    always_comb begin
        if (line_end) begin
            xpos_next = geom.xpos_start;
        end else if (cycle_num == 7'd0 && cycle_bit == 3'd0) begin
            xpos_next = geom.xpos_cycle0;
        end else if (geom.is_r8 && cycle_num == 7'd60 && cycle_bit == 3'd7) begin
            xpos_next = XPOS_R8_HOLD;
        end else if (geom.is_r8 && cycle_num == 7'd61 &&
                     (cycle_bit == 3'd3 || cycle_bit == 3'd7)) begin
            xpos_next = XPOS_R8_HOLD;
        end else if (cycle_num == 7'd12 && cycle_bit == 3'd3) begin
            xpos_next = '0;
        end else begin
            xpos_next = pos.xpos + X_ONE;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // geometry is stable from the second reset cycle
            pos.xpos            <= geom.xpos_start;
            pos.sprite_raster_x <= geom.sprite_start;
            pos.raster_x        <= '0;
            pos.raster_line     <= '0;
            pos.raster_line_d   <= '0;
        end else begin
            // delayed line number follows raster_line in the phi high half
            if (strobes.phi) begin
                pos.raster_line_d <= pos.raster_line;
            end

            if (strobes.dot_rising) begin
                pos.xpos            <= xpos_next;
                pos.sprite_raster_x <= sprite_next;
                if (line_end) begin
                    pos.raster_x <= '0;
                    if (frame_end) begin
                        pos.raster_line <= '0;
                    end else begin
                        pos.raster_line <= pos.raster_line + Y_ONE;
                    end
                end else begin
                    pos.raster_x <= pos.raster_x + X_ONE;
                end
            end
        end
    end

endmodule

// File: design/chip_geometry_decode.sv
`timescale 1ns/1ns

module chip_geometry_decode (
    input  logic                         clk_dot4x,
    input  logic                         rst,
    input  vic_chip_pkg::chip_model_t    chip,
    output vic_chip_pkg::chip_geometry_t geom
);

    // model captured while the block is held in reset
    vic_chip_pkg::chip_model_t chip_q;

    function automatic vic_chip_pkg::chip_geometry_t geometry_of(
        input vic_chip_pkg::chip_model_t model
    );
        vic_chip_pkg::chip_geometry_t g;
        g = '0;
        case (model)
            vic_chip_pkg::CHIP6567R56A: begin
                g.raster_x_max = 10'd511;
                g.raster_y_max = 9'd261;
                g.xpos_start   = 10'h19c;
                g.xpos_cycle0  = 10'h19d;
                g.sprite_start = 10'd72;
                g.hsync_start  = 10'h18c;
                g.hsync_end    = 10'h1bc;
                g.vblank_end   = 9'd28;
            end
            vic_chip_pkg::CHIP6567R8: begin
                // one extra cycle per line, so the sprite counter starts 8 later
                g.raster_x_max = 10'd519;
                g.raster_y_max = 9'd262;
                g.xpos_start   = 10'h19c;
                g.xpos_cycle0  = 10'h19d;
                g.sprite_start = 10'd80;
                g.hsync_start  = 10'h18c;
                g.hsync_end    = 10'h1bc;
                g.vblank_end   = 9'd28;
                g.is_r8        = 1'b1;
            end
            vic_chip_pkg::CHIP6569R1, vic_chip_pkg::CHIP6569R3: begin
                g.raster_x_max = 10'd503;
                g.raster_y_max = 9'd311;
                g.xpos_start   = 10'h194;
                g.xpos_cycle0  = 10'h195;
                g.sprite_start = 10'd72;
                g.hsync_start  = 10'h17c;
                g.hsync_end    = 10'h1ac;
                g.vblank_end   = 9'd16;
            end
        endcase
        return g;
    endfunction

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            chip_q <= chip;
        end
    end

    // settles one cycle after the model is captured
    always_ff @(posedge clk_dot4x) begin
        geom <= geometry_of(chip_q);
    end

endmodule

// File: design/dot_phase_gen.sv
`timescale 1ns/1ns
`include "vic_settings.svh"

module dot_phase_gen (
    input  logic                         clk_dot4x,
    input  logic                         rst,
    output vic_raster_pkg::dot_strobes_t strobes
);

    localparam int TICK_BITS = $clog2(`VIC_TICKS_PER_PHI);

    localparam logic [TICK_BITS-1:0] TICK_ONE = TICK_BITS'(1);
    // low tick bits that select the pixel within a processor cycle
    localparam logic [TICK_BITS-1:0] DOT_MASK = TICK_BITS'(`VIC_TICKS_PER_DOT - 1);
    // first tick of the phi high half
    localparam logic [TICK_BITS-1:0] PHI_HALF = TICK_BITS'(`VIC_TICKS_PER_PHI / 2);

    // position within the current processor cycle
    logic [TICK_BITS-1:0] tick_q;

    logic dot_rising_d;
    logic phi_d;
    logic phi_start_d;

    assign dot_rising_d = (tick_q & DOT_MASK) == '0;
    assign phi_d        = tick_q >= PHI_HALF;
    assign phi_start_d  = (tick_q == '0) || (tick_q == PHI_HALF);

    // strobes are registered, so they describe the tick held one cycle earlier
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick_q  <= '0;
            strobes <= '0;
        end else begin
            tick_q             <= tick_q + TICK_ONE;
            strobes.dot_rising <= dot_rising_d;
            strobes.phi        <= phi_d;
            strobes.phi_start  <= phi_start_d;
        end
    end

endmodule

// File: design/vic_raster_pkg.sv
`include "vic_settings.svh"

package vic_raster_pkg;

    // strobes derived from clk_dot4x
    typedef struct packed {
        logic dot_rising;
        logic phi;
        logic phi_start;
    } dot_strobes_t;

    // current raster position
    typedef struct packed {
        logic [`VIC_X_BITS-1:0] xpos;
        logic [`VIC_X_BITS-1:0] raster_x;
        logic [`VIC_X_BITS-1:0] sprite_raster_x;
        logic [`VIC_Y_BITS-1:0] raster_line;
        logic [`VIC_Y_BITS-1:0] raster_line_d;
    } raster_pos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank;
    } sync_out_t;

endpackage

// File: design/vic_chip_pkg.sv
`include "vic_settings.svh"

package vic_chip_pkg;

    // same encoding as the chip select pins of the board
    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,
        CHIP6569R3   = 2'd1,
        CHIP6567R56A = 2'd2,
        CHIP6569R1   = 2'd3
    } chip_model_t;

    // line and frame geometry of one chip model
    typedef struct packed {
        // last pixel of a line and last line of a frame
        logic [`VIC_X_BITS-1:0] raster_x_max;
        logic [`VIC_Y_BITS-1:0] raster_y_max;
        // xpos at the start of the line and the value reloaded in cycle 0
        logic [`VIC_X_BITS-1:0] xpos_start;
        logic [`VIC_X_BITS-1:0] xpos_cycle0;
        // sprite counter value after reset
        logic [`VIC_X_BITS-1:0] sprite_start;
        // hsync window in xpos units
        logic [`VIC_X_BITS-1:0] hsync_start;
        logic [`VIC_X_BITS-1:0] hsync_end;
        // first line after vertical blank
        logic [`VIC_Y_BITS-1:0] vblank_end;
        // 6567R8 holds xpos twice near the end of the line
        logic                   is_r8;
    } chip_geometry_t;

endpackage

// File: design/vic_settings.svh
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// horizontal counters reach 519 on the widest line
`define VIC_X_BITS 10

// line counters reach 311 on the tallest frame
`define VIC_Y_BITS 9

// clk_dot4x ticks per pixel
`define VIC_TICKS_PER_DOT 4

// clk_dot4x ticks per processor cycle of eight pixels
`define VIC_TICKS_PER_PHI 32

`endif
